//--- verilog.f
fetch_pkg.sv
fetch_pc.sv
imem_port.sv
pair_buffer.sv
fetch_top.sv
tb_clock.sv
tb_imem_model.sv
tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - fetch_pkg.sv
  - fetch_pc.sv
  - imem_port.sv
  - pair_buffer.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tb_imem_model.sv
      - tb_fetch.sv

//--- tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam word_t START_PC = 32'h0000_1000;
    localparam word_t DATA_MASK = 32'ha5a5_0000;
    localparam logic [31:0] SEED = 32'he0be84f8;
    localparam int CLK_PERIOD = 8;
    // watchdog budget
    localparam int PAIR_CYCLES = 40;
    localparam int EXPECTED_PAIRS = 36;
    localparam int MARGIN_CYCLES = 120;

    // redirect targets
    localparam word_t BRANCH_UPPER_PC = 32'h0000_2004;
    localparam word_t EXC_PC = 32'h0000_0180;
    localparam word_t PRED_PC = 32'h0000_5000;
    localparam word_t LOST_BRANCH_PC = 32'h0000_6000;
    localparam word_t MISALIGNED_PC = 32'h0000_3002;

    logic clk;
    logic reset;
    logic exc_valid;
    word_t exc_pc;
    logic branch_valid;
    word_t branch_pc;
    logic pred_valid;
    word_t pred_pc;
    logic imem_req;
    word_t imem_addr;
    logic imem_ack;
    pair_t imem_data;
    logic pair_req;
    word_t pair_pc;
    instr_t slot0_instr;
    instr_t slot1_instr;
    logic slot1_valid;
    logic fetch_exc;
    logic pair_ack = 1'b0;

    // pairs accepted on the decode side, in order
    word_t got_pc[$];
    logic got_exc[$];
    int taken = 0;
    word_t last_pc;

    // imem requests seen on the bus
    word_t req_addrs[$];
    int imem_reqs = 0;
    logic req_seen = 1'b0;

    int errors = 0;
    logic hold_ack = 1'b0;
    logic [31:0] rnd_state = SEED;
    int ack_wait = 0;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clock (.clk(clk), .reset(reset));

    tb_imem_model #(.SEED(SEED), .MAX_DELAY(5)) u_imem (
        .clk(clk),
        .reset(reset),
        .i_req(imem_req),
        .i_addr(imem_addr),
        .o_ack(imem_ack),
        .o_data(imem_data)
    );

    fetch_top #(.RESET_PC(START_PC)) dut0 (
        .clk(clk),
        .reset(reset),
        .i_exc_valid(exc_valid),
        .i_exc_pc(exc_pc),
        .i_branch_valid(branch_valid),
        .i_branch_pc(branch_pc),
        .i_pred_valid(pred_valid),
        .i_pred_pc(pred_pc),
        .o_imem_req(imem_req),
        .o_imem_addr(imem_addr),
        .i_imem_ack(imem_ack),
        .i_imem_data(imem_data),
        .o_pair_req(pair_req),
        .o_pair_pc(pair_pc),
        .o_slot0_instr(slot0_instr),
        .o_slot1_instr(slot1_instr),
        .o_slot1_valid(slot1_valid),
        .o_fetch_exc(fetch_exc),
        .i_pair_ack(pair_ack)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory contents at a word address
    function automatic instr_t model_instr(input word_t addr);
        return {addr[31:2], 2'b00} ^ DATA_MASK;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    // pair on the decode port against the memory contents
    task automatic check_pair();
        logic exp_exc;
        logic exp_slot1;
        exp_exc = (pair_pc[1:0] != 2'b00);
        exp_slot1 = !exp_exc && !pair_pc[2];
        if (fetch_exc !== exp_exc)
            report_mismatch("o_fetch_exc", exp_exc, fetch_exc);
        if (slot1_valid !== exp_slot1)
            report_mismatch("o_slot1_valid", exp_slot1, slot1_valid);
        if (exp_exc) begin
            if (slot0_instr !== '0)
                report_mismatch("o_slot0_instr", '0, slot0_instr);
            if (slot1_instr !== '0)
                report_mismatch("o_slot1_instr", '0, slot1_instr);
        end else begin
            if (slot0_instr !== model_instr(pair_pc))
                report_mismatch("o_slot0_instr", model_instr(pair_pc), slot0_instr);
            if (exp_slot1 && slot1_instr !== model_instr(pair_pc + 32'd4))
                report_mismatch("o_slot1_instr", model_instr(pair_pc + 32'd4), slot1_instr);
        end
    endtask

    // decode side, acks after a random delay unless stalled
    always @(negedge clk) begin
        if (reset) begin
            pair_ack <= 1'b0;
        end else if (pair_req && !pair_ack && !hold_ack) begin
            if (ack_wait == 0) begin
                check_pair();
                got_pc.push_back(pair_pc);
                got_exc.push_back(fetch_exc);
                pair_ack <= 1'b1;
                rnd_state = xorshift32(rnd_state);
                ack_wait = rnd_state % 4;
            end else begin
                ack_wait--;
            end
        end else if (!pair_req && pair_ack) begin
            pair_ack <= 1'b0;
        end
    end

    // count imem requests on their rising edge
    always @(negedge clk) begin
        if (!reset && imem_req && !req_seen) begin
            imem_reqs++;
            req_addrs.push_back(imem_addr);
            if (imem_addr[2:0] != 3'b000)
                report_failure("imem request carries an unaligned address");
        end
        req_seen = imem_req;
    end

    initial begin
        #(CLK_PERIOD * (PAIR_CYCLES * EXPECTED_PAIRS + MARGIN_CYCLES));
        $display("timeout: decode stopped receiving pairs after %0d", got_pc.size());
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic redirect_cycle(input logic exc, input word_t exc_target,
                                  input logic br, input word_t br_target,
                                  input logic pred, input word_t pred_target);
        @(negedge clk);
        exc_valid = exc;
        exc_pc = exc_target;
        branch_valid = br;
        branch_pc = br_target;
        pred_valid = pred;
        pred_pc = pred_target;
    endtask

    // next accepted pair, in order
    task automatic next_pair(output word_t pc);
        while (got_pc.size() <= taken) @(negedge clk);
        pc = got_pc[taken];
        taken++;
    endtask

    // pc must follow the previous pair's aligned address by 8
    task automatic check_sequential(input word_t pc);
        word_t exp_pc;
        exp_pc = {last_pc[31:3], 3'b000} + 32'd8;
        if (pc !== exp_pc)
            report_mismatch("o_pair_pc", exp_pc, pc);
        last_pc = pc;
    endtask

    // older sequential pairs may still drain before the target
    task automatic find_target(input word_t target);
        word_t pc;
        int n;
        n = 0;
        pc = '0;
        while (n < 4 && pc !== target) begin
            next_pair(pc);
            if (pc !== target)
                check_sequential(pc);
            n++;
        end
        if (pc !== target)
            report_failure($sformatf("redirect target %h never reached decode", target));
        else
            last_pc = target;
    endtask

    task automatic test_boot_sequence();
        word_t pc;
        next_pair(pc);
        if (pc !== START_PC)
            report_mismatch("o_pair_pc", START_PC, pc);
        last_pc = pc;
        repeat (6) begin
            next_pair(pc);
            check_sequential(pc);
        end
    endtask

    task automatic test_branch_upper();
        word_t pc;
        redirect_cycle(1'b0, '0, 1'b1, BRANCH_UPPER_PC, 1'b0, '0);
        redirect_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
        find_target(BRANCH_UPPER_PC);
        next_pair(pc);
        check_sequential(pc);
    endtask

    task automatic test_priority();
        word_t pc;
        int first;
        first = taken;
        // exception beats prediction, then a lower branch arrives late
        redirect_cycle(1'b1, EXC_PC, 1'b0, '0, 1'b1, PRED_PC);
        redirect_cycle(1'b0, '0, 1'b1, LOST_BRANCH_PC, 1'b0, '0);
        redirect_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
        find_target(EXC_PC);
        repeat (2) begin
            next_pair(pc);
            check_sequential(pc);
        end
        for (int i = first; i < taken; i++) begin
            if (got_pc[i] === PRED_PC)
                report_failure("prediction target fetched despite a pending exception");
            if (got_pc[i] === LOST_BRANCH_PC)
                report_failure("branch target fetched despite a pending exception");
        end
    endtask

    task automatic test_misaligned();
        word_t pc;
        int first_req;
        first_req = req_addrs.size();
        redirect_cycle(1'b0, '0, 1'b1, MISALIGNED_PC, 1'b0, '0);
        redirect_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
        find_target(MISALIGNED_PC);
        if (got_exc[taken - 1] !== 1'b1)
            report_mismatch("o_fetch_exc", 1'b1, got_exc[taken - 1]);
        next_pair(pc);
        check_sequential(pc);
        for (int i = first_req; i < req_addrs.size(); i++) begin
            if (req_addrs[i] === {MISALIGNED_PC[31:3], 3'b000})
                report_failure("imem request issued for a misaligned target");
        end
    endtask

    task automatic test_backpressure();
        word_t pc;
        int reqs_before;
        @(negedge clk);
        hold_ack = 1'b1;
        @(negedge clk);
        reqs_before = imem_reqs;
        repeat (50) @(negedge clk);
        // one fetch may fill the entry, nothing after that
        if (imem_reqs - reqs_before > 1)
            report_failure("more than one imem request while decode stalled");
        hold_ack = 1'b0;
        repeat (6) begin
            next_pair(pc);
            check_sequential(pc);
        end
    endtask

    initial begin
        exc_valid = 1'b0;
        exc_pc = '0;
        branch_valid = 1'b0;
        branch_pc = '0;
        pred_valid = 1'b0;
        pred_pc = '0;
        last_pc = '0;
        @(negedge reset);
        test_boot_sequence();
        test_branch_upper();
        test_priority();
        test_misaligned();
        test_backpressure();
        $display("errors: %0d, pairs checked: %0d, imem requests: %0d",
                 errors, got_pc.size(), imem_reqs);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb_imem_model.sv
`timescale 1ns/1ps

module tb_imem_model
    import fetch_pkg::*;
#(
    parameter logic [31:0] SEED = 32'he0be84f8,
    parameter int MAX_DELAY = 5
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  i_req,
    input  word_t i_addr,
    output logic  o_ack,
    output pair_t o_data
);

    // scrambles every instruction so slots cannot be confused
    localparam word_t DATA_MASK = 32'ha5a5_0000;

    logic ack_q = 1'b0;
    pair_t data_q = '0;
    logic [31:0] rnd_state = SEED;
    // cycles left before ack
    int wait_left = 0;
    // latency already drawn for the current req
    logic busy = 1'b0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // lower half is the word at addr, upper half the one at addr + 4
    function automatic pair_t mem_word(input word_t addr);
        return {(addr + 32'd4) ^ DATA_MASK, addr ^ DATA_MASK};
    endfunction

    // responder side, driven on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            busy = 1'b0;
        end else if (i_req && !ack_q) begin
            if (!busy) begin
                // new request, pick its latency
                rnd_state = xorshift32(rnd_state);
                wait_left = rnd_state % (MAX_DELAY + 1);
                busy = 1'b1;
            end
            if (wait_left == 0) begin
                // data goes out with ack
                ack_q <= 1'b1;
                data_q <= mem_word(i_addr);
            end else begin
                wait_left--;
            end
        end else if (!i_req && ack_q) begin
            // requester released, finish the four phases
            ack_q <= 1'b0;
            busy = 1'b0;
        end
    end

    assign o_ack = ack_q;
    assign o_data = data_q;

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset drops on a falling edge, clear of the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic   clk,
    input  logic   reset,

    // redirects from exception, execute and issue
    input  logic   i_exc_valid,
    input  word_t  i_exc_pc,
    input  logic   i_branch_valid,
    input  word_t  i_branch_pc,
    input  logic   i_pred_valid,
    input  word_t  i_pred_pc,

    // instruction memory
    output logic   o_imem_req,
    output word_t  o_imem_addr,
    input  logic   i_imem_ack,
    input  pair_t  i_imem_data,

    // decode
    output logic   o_pair_req,
    output word_t  o_pair_pc,
    output instr_t o_slot0_instr,
    output instr_t o_slot1_instr,
    output logic   o_slot1_valid,
    output logic   o_fetch_exc,
    input  logic   i_pair_ack
);

    // fetch_pc to imem_port
    word_t pc;
    logic pc_stale;
    logic fetch_start;

    // imem_port to pair_buffer
    logic word_valid;
    pair_t word;
    logic misaligned;
    word_t start_pc;
    logic buf_free;

    fetch_pc #(
        .RESET_PC(RESET_PC)
    ) u_fetch_pc (
        .clk(clk),
        .reset(reset),
        .i_exc_valid(i_exc_valid),
        .i_exc_pc(i_exc_pc),
        .i_branch_valid(i_branch_valid),
        .i_branch_pc(i_branch_pc),
        .i_pred_valid(i_pred_valid),
        .i_pred_pc(i_pred_pc),
        .i_fetch_start(fetch_start),
        .o_pc(pc),
        .o_pc_stale(pc_stale)
    );

    imem_port u_imem_port (
        .clk(clk),
        .reset(reset),
        .i_pc(pc),
        .i_pc_stale(pc_stale),
        .i_buf_free(buf_free),
        .o_imem_req(o_imem_req),
        .o_imem_addr(o_imem_addr),
        .i_imem_ack(i_imem_ack),
        .i_imem_data(i_imem_data),
        .o_fetch_start(fetch_start),
        .o_word_valid(word_valid),
        .o_word(word),
        .o_misaligned(misaligned),
        .o_start_pc(start_pc)
    );

    // pair pc is the one latched at fetch start, not the advanced register
    pair_buffer u_pair_buffer (
        .clk(clk),
        .reset(reset),
        .i_word_valid(word_valid),
        .i_word(word),
        .i_misaligned(misaligned),
        .i_pc(start_pc),
        .o_buf_free(buf_free),
        .o_pair_req(o_pair_req),
        .o_pair_pc(o_pair_pc),
        .o_slot0_instr(o_slot0_instr),
        .o_slot1_instr(o_slot1_instr),
        .o_slot1_valid(o_slot1_valid),
        .o_fetch_exc(o_fetch_exc),
        .i_pair_ack(i_pair_ack)
    );

endmodule

//--- pair_buffer.sv
`timescale 1ns/1ps

module pair_buffer
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // captured word from imem_port
    input  logic   i_word_valid,
    input  pair_t  i_word,
    input  logic   i_misaligned,
    input  word_t  i_pc,

    output logic   o_buf_free,

    // decode side four-phase handshake
    output logic   o_pair_req,
    output word_t  o_pair_pc,
    output instr_t o_slot0_instr,
    output instr_t o_slot1_instr,
    output logic   o_slot1_valid,
    output logic   o_fetch_exc,
    input  logic   i_pair_ack
);

    // entry occupied
    logic full_q;
    logic req_q;

    // held pair
    word_t pc_q;
    instr_t slot0_q;
    instr_t slot1_q;
    logic slot1_valid_q;
    logic exc_q;

    // split of the incoming word
    instr_t lo_instr;
    instr_t hi_instr;
    instr_t slot0_d;
    instr_t slot1_d;
    logic slot1_valid_d;

    assign lo_instr = i_word[31:0];
    assign hi_instr = i_word[63:32];

    always_comb begin
        slot0_d = lo_instr;
        slot1_d = hi_instr;
        slot1_valid_d = 1'b1;
        if (i_misaligned) begin
            // address error, nothing fetched
            slot0_d = '0;
            slot1_d = '0;
            slot1_valid_d = 1'b0;
        end else if (i_pc[2]) begin
            // pc at the upper word, only one instruction left
            slot0_d = hi_instr;
            slot1_d = '0;
            slot1_valid_d = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full_q <= 1'b0;
            req_q <= 1'b0;
        end else begin
            if (i_word_valid) begin
                // offer the pair in the cycle after capture
                full_q <= 1'b1;
                req_q <= 1'b1;
            end else if (req_q && i_pair_ack) begin
                // decode took it, drop req
                req_q <= 1'b0;
            end else if (full_q && !req_q && !i_pair_ack) begin
                // ack seen low, entry free again
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_word_valid) begin
            pc_q <= i_pc;
            slot0_q <= slot0_d;
            slot1_q <= slot1_d;
            slot1_valid_q <= slot1_valid_d;
            exc_q <= i_misaligned;
        end
    end

    assign o_buf_free = !full_q;
    assign o_pair_req = req_q;
    assign o_pair_pc = pc_q;
    assign o_slot0_instr = slot0_q;
    assign o_slot1_instr = slot1_q;
    assign o_slot1_valid = slot1_valid_q;
    assign o_fetch_exc = exc_q;

    // req stays up until decode acks
    assert property (@(posedge clk) disable iff (reset)
        (o_pair_req && !i_pair_ack) |=> o_pair_req)
        else $error("pair req dropped before ack");

    // imem side never delivers into an occupied entry
    assert property (@(posedge clk) disable iff (reset)
        i_word_valid |-> o_buf_free)
        else $error("word delivered while pair buffer full");

endmodule

//--- imem_port.sv
`timescale 1ns/1ps

module imem_port
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // from fetch_pc
    input  word_t i_pc,
    input  logic  i_pc_stale,

    // from pair_buffer
    input  logic  i_buf_free,

    // instruction memory four-phase handshake
    output logic  o_imem_req,
    output word_t o_imem_addr,
    input  logic  i_imem_ack,
    input  pair_t i_imem_data,

    output logic  o_fetch_start,

    // captured word towards pair_buffer
    output logic  o_word_valid,
    output pair_t o_word,
    output logic  o_misaligned,
    output word_t o_start_pc
);

    imem_state_t state;

    // current fetch was overtaken by a redirect
    logic stale_q;
    logic word_valid_q;

    // pc of the fetch in progress, low bits kept
    word_t start_pc_q;
    pair_t word_q;

    logic start;
    logic pc_misaligned;

    assign pc_misaligned = |i_pc[1:0];

    // hold off while a captured word is still on its way to the buffer
    assign start = (state == IMEM_IDLE) && i_buf_free && !word_valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IMEM_IDLE;
            stale_q <= 1'b0;
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= 1'b0;
            unique case (state)
                IMEM_IDLE: begin
                    if (start) begin
                        stale_q <= i_pc_stale;
                        // misaligned pc completes here, no bus cycle
                        if (pc_misaligned) begin
                            word_valid_q <= !i_pc_stale;
                        end else begin
                            state <= IMEM_REQ;
                        end
                    end
                end
                IMEM_REQ: begin
                    if (i_pc_stale) begin
                        stale_q <= 1'b1;
                    end
                    // data is valid with ack, drop req next
                    if (i_imem_ack) begin
                        state <= IMEM_RELEASE;
                        word_valid_q <= !stale_q && !i_pc_stale;
                    end
                end
                IMEM_RELEASE: begin
                    // wait for ack low before another req
                    if (!i_imem_ack) begin
                        state <= IMEM_IDLE;
                    end
                end
                default: begin
                    state <= IMEM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            start_pc_q <= i_pc;
        end
        if ((state == IMEM_REQ) && i_imem_ack) begin
            word_q <= i_imem_data;
        end
    end

    assign o_imem_req = (state == IMEM_REQ);
    // memory only ever sees the aligned pair address
    assign o_imem_addr = {start_pc_q[31:3], 3'b000};
    assign o_fetch_start = start;
    assign o_word_valid = word_valid_q;
    assign o_word = word_q;
    assign o_misaligned = |start_pc_q[1:0];
    assign o_start_pc = start_pc_q;

    // address held until the responder acks
    assert property (@(posedge clk) disable iff (reset)
        (o_imem_req && !i_imem_ack) |=> $stable(o_imem_addr))
        else $error("imem address changed while waiting for ack");

    // four-phase: ack must be low before req rises again
    assert property (@(posedge clk) disable iff (reset)
        $rose(o_imem_req) |-> !$past(i_imem_ack))
        else $error("imem req raised while ack still high");

endmodule

//--- fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc
    import fetch_pkg::*;
#(
    parameter word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic  clk,
    input  logic  reset,

    // redirect pulses with their targets
    input  logic  i_exc_valid,
    input  word_t i_exc_pc,
    input  logic  i_branch_valid,
    input  word_t i_branch_pc,
    input  logic  i_pred_valid,
    input  word_t i_pred_pc,

    // pulse from imem_port when a fetch begins
    input  logic  i_fetch_start,

    output word_t o_pc,
    output logic  o_pc_stale
);

    // sequential fetch address
    word_t pc_q;

    // pending redirect whose kind is also its rank
    redirect_kind_t pend_kind;
    word_t pend_pc;

    // best redirect arriving this cycle
    redirect_kind_t arr_kind;
    word_t arr_pc;
    logic arr_any;
    logic arr_take;

    // current fetch address with the byte offset cleared
    word_t pc_aligned;

    // exception outranks branch, branch outranks prediction
    always_comb begin
        arr_kind = REDIR_NONE;
        arr_pc = '0;
        if (i_exc_valid) begin
            arr_kind = REDIR_EXC;
            arr_pc = i_exc_pc;
        end else if (i_branch_valid) begin
            arr_kind = REDIR_BRANCH;
            arr_pc = i_branch_pc;
        end else if (i_pred_valid) begin
            arr_kind = REDIR_PRED;
            arr_pc = i_pred_pc;
        end
    end

    assign arr_any = i_exc_valid | i_branch_valid | i_pred_valid;

    // an equal or higher rank replaces the pending redirect
    // in a start cycle this compares against the kind being fetched
    assign arr_take = arr_any && (arr_kind >= pend_kind);

    // a pending target overrides the sequential address
    assign o_pc = (pend_kind != REDIR_NONE) ? pend_pc : pc_q;

    assign pc_aligned = {o_pc[31:3], 3'b000};

    // only a redirect that takes effect makes the in-flight fetch stale
    assign o_pc_stale = arr_take;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
            pend_kind <= REDIR_NONE;
        end else begin
            // next sequential pair after the one just started
            if (i_fetch_start) begin
                pc_q <= pc_aligned + PAIR_BYTES;
            end
            // pending slot consumed by the start unless refilled
            if (arr_take) begin
                pend_kind <= arr_kind;
            end else if (i_fetch_start) begin
                pend_kind <= REDIR_NONE;
            end
        end
    end

    // target of the pending redirect
    always_ff @(posedge clk) begin
        if (arr_take) begin
            pend_pc <= arr_pc;
        end
    end

    // a quiet fetch start always drains the pending redirect
    assert property (@(posedge clk) disable iff (reset)
        (i_fetch_start && !arr_any) |=> (pend_kind == REDIR_NONE))
        else $error("pending redirect kept after a fetch start");

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    // address or data word
    typedef logic [31:0] word_t;

    // one mips instruction
    typedef logic [31:0] instr_t;

    // 64-bit imem word, lower half at the lower address
    typedef logic [63:0] pair_t;

    // bytes covered by one imem word
    localparam word_t PAIR_BYTES = 32'd8;

    // requester side of the four-phase imem handshake
    typedef enum logic [1:0] {
        // waiting for a free buffer
        IMEM_IDLE,
        // req high, waiting for ack
        IMEM_REQ,
        // req dropped, waiting for ack low
        IMEM_RELEASE
    } imem_state_t;

    // pending redirect kind
    // encoding order is the priority rank, higher wins
    typedef enum logic [1:0] {
        REDIR_NONE   = 2'd0,
        // jr ra return prediction from issue
        REDIR_PRED   = 2'd1,
        // branch resolved in execute
        REDIR_BRANCH = 2'd2,
        // exception or eret entrance
        REDIR_EXC    = 2'd3
    } redirect_kind_t;

endpackage
